/* logic/ibuf_pkg.sv */
// instruction buffer package: line geometry, field widths and shared packed types
`default_nettype none

package ibuf_pkg;

    // ----------------------------------------------------------------------
    // geometry
    // ----------------------------------------------------------------------

    // byte offset within a 16-byte cache line
    localparam int OFFSET_WIDTH = 4;
    // 16-bit parcels per line
    localparam int HALVES_PER_LINE = 8;
    // two lines in the buffer, addressed by a 1-bit pointer
    localparam int NUM_LINES = 2;
    localparam int LINE_IDX_WIDTH = 1;

    // field widths
    localparam int PC_WIDTH = 32;
    localparam int ECAUSE_WIDTH = 6;
    localparam int HALF_WIDTH = 16;

    // ----------------------------------------------------------------------
    // basic types
    // ----------------------------------------------------------------------

    typedef logic [PC_WIDTH-1:0] pc_t;
    typedef logic [ECAUSE_WIDTH-1:0] ecause_t;
    typedef logic [HALF_WIDTH-1:0] half_t;

    // halfword 0 sits at the lowest pc of the line
    typedef half_t [HALVES_PER_LINE-1:0] line_data_t;

    // per-line tag and fetch fault, base_pc has its offset bits at zero
    typedef struct packed {
        pc_t     base_pc;
        logic    excp_valid;
        ecause_t ecause;
    } line_info_t;

    // one line as the cache hands it over
    typedef struct packed {
        line_info_t info;
        line_data_t data;
    } line_in_t;

    // one instruction offered to decode
    // compressed opcodes are zero-extended into the upper half of instr
    typedef struct packed {
        logic    valid;
        pc_t     pc;
        pc_t     next_pc;
        logic [31:0] instr;
        logic    is_rv;
        logic    excp_valid;
        ecause_t ecause;
    } slot_t;

    // SYNC drops lines until the one holding pc shows up
    typedef enum logic [0:0] {
        SYNC   = 1'b0,
        STREAM = 1'b1
    } sync_state_t;

endpackage

`default_nettype wire

/* logic/line_regs.sv */
// line storage: one register entry per buffer line, written by line index
`default_nettype none

module line_regs #(
    parameter type entry_t = logic [15:0]
) (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                wr_en_i,
    input  wire logic [ibuf_pkg::LINE_IDX_WIDTH-1:0] wr_idx_i,
    input  wire entry_t                              wr_data_i,
    output entry_t                                   entries_o [ibuf_pkg::NUM_LINES]
);

    import ibuf_pkg::*;

    // one entry per line, all of them visible to the extractor
    entry_t entries_q [NUM_LINES];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                entries_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            // only the addressed line changes
            entries_q[wr_idx_i] <= wr_data_i;
        end
    end

    assign entries_o = entries_q;

endmodule

`default_nettype wire

/* logic/ibuf_pointers.sv */
// buffer pointers: fetch pc, pop and push line pointers and per-line valid bits
`default_nettype none

module ibuf_pointers #(
    parameter ibuf_pkg::pc_t RESET_PC = 32'h0000_1000
) (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                flush_i,
    input  wire ibuf_pkg::pc_t                       flush_pc_i,
    input  wire logic                                push_i,
    input  wire logic                                take_i,
    input  wire logic [2:0]                          pop_halves_i,
    output ibuf_pkg::pc_t                            pc_o,
    output logic [ibuf_pkg::LINE_IDX_WIDTH-1:0]      pop_line_o,
    output logic [ibuf_pkg::LINE_IDX_WIDTH-1:0]      push_line_o,
    output logic [ibuf_pkg::NUM_LINES-1:0]           line_valid_o,
    output logic                                     has_free_o
);

    import ibuf_pkg::*;

    pc_t                       pc_q;
    logic [LINE_IDX_WIDTH-1:0] pop_line_q;
    logic [LINE_IDX_WIDTH-1:0] push_line_q;
    logic [NUM_LINES-1:0]      line_valid_q;

    pc_t                       pc_step;
    pc_t                       pc_next;
    logic                      leave_line;
    logic [NUM_LINES-1:0]      valid_next;

    // ----------------------------------------------------------------------
    // pop side
    // ----------------------------------------------------------------------

    // two bytes per consumed halfword
    assign pc_step = pc_t'({pop_halves_i, 1'b0});
    assign pc_next = pc_q + pc_step;

    // at most four halves per take, so at most one line boundary is crossed
    assign leave_line = take_i &&
        (pc_next[PC_WIDTH-1:OFFSET_WIDTH] != pc_q[PC_WIDTH-1:OFFSET_WIDTH]);

    // line vacated by the pop point frees on the same edge
    // a push never targets the popped line since that line is still occupied
    always_comb begin
        valid_next = line_valid_q;
        if (leave_line) begin
            valid_next[pop_line_q] = 1'b0;
        end
        if (push_i) begin
            valid_next[push_line_q] = 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // state
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q         <= RESET_PC;
            pop_line_q   <= '0;
            push_line_q  <= '0;
            line_valid_q <= '0;
        end else if (flush_i) begin
            // redirect, empty buffer, restart both pointers at line 0
            pc_q         <= flush_pc_i;
            pop_line_q   <= '0;
            push_line_q  <= '0;
            line_valid_q <= '0;
        end else begin
            if (take_i) begin
                pc_q <= pc_next;
            end
            if (leave_line) begin
                pop_line_q <= pop_line_q + LINE_IDX_WIDTH'(1);
            end
            if (push_i) begin
                push_line_q <= push_line_q + LINE_IDX_WIDTH'(1);
            end
            line_valid_q <= valid_next;
        end
    end

    assign pc_o         = pc_q;
    assign pop_line_o   = pop_line_q;
    assign push_line_o  = push_line_q;
    assign line_valid_o = line_valid_q;
    // room for another line as long as one slot is empty
    assign has_free_o   = ~&line_valid_q;

endmodule

`default_nettype wire

/* logic/fetch_sync_fsm.sv */
// fetch sync FSM: drops stale lines after a flush and gates line storage
`default_nettype none

module fetch_sync_fsm (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          flush_i,
    input  wire logic          line_valid_i,
    input  wire ibuf_pkg::pc_t line_base_i,
    input  wire ibuf_pkg::pc_t pc_i,
    input  wire logic          has_free_i,
    output logic               line_ready_o,
    output logic               store_o
);

    import ibuf_pkg::*;

    sync_state_t state_q;
    logic        tag_match;
    logic        accept;

    // line holds the current fetch pc
    assign tag_match = (line_base_i[PC_WIDTH-1:OFFSET_WIDTH] == pc_i[PC_WIDTH-1:OFFSET_WIDTH]);

    // sync always drains the cache, stream waits for a free line
    assign line_ready_o = (state_q == SYNC) ? 1'b1 : has_free_i;
    assign accept = line_valid_i && line_ready_o;

    // flush wins, so nothing is written on a flush edge
    // in sync only the matching line is kept, anything else is thrown away
    assign store_o = accept && !flush_i && ((state_q == STREAM) || tag_match);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= SYNC;
        end else if (flush_i) begin
            state_q <= SYNC;
        end else if ((state_q == SYNC) && store_o) begin
            // first line of the new stream is being stored
            state_q <= STREAM;
        end
    end

endmodule

`default_nettype wire

/* logic/insn_extract.sv */
// instruction extractor: four-halfword window, RVC length decode and two decode slots
`default_nettype none

module insn_extract (
    input  wire ibuf_pkg::line_data_t                lines_i [ibuf_pkg::NUM_LINES],
    input  wire ibuf_pkg::line_info_t                infos_i [ibuf_pkg::NUM_LINES],
    input  wire logic [ibuf_pkg::NUM_LINES-1:0]      line_valid_i,
    input  wire logic [ibuf_pkg::LINE_IDX_WIDTH-1:0] pop_line_i,
    input  wire ibuf_pkg::pc_t                       pc_i,
    output ibuf_pkg::slot_t                          slot0_o,
    output ibuf_pkg::slot_t                          slot1_o,
    output logic [2:0]                               pop_halves_o
);

    import ibuf_pkg::*;

    // one halfword of the window with where it came from
    typedef struct packed {
        logic    avail;
        half_t   data;
        logic    excp_valid;
        ecause_t ecause;
    } win_half_t;

    localparam int WIN_HALVES = 4;

    win_half_t                 win [WIN_HALVES];
    logic [OFFSET_WIDTH-2:0]   start_half;
    logic [OFFSET_WIDTH-1:0]   half_pos [WIN_HALVES];
    logic [LINE_IDX_WIDTH-1:0] half_line [WIN_HALVES];
    logic [2:0]                len0;
    logic [2:0]                len1;

    // ----------------------------------------------------------------------
    // slot builder
    // ----------------------------------------------------------------------

    // first and second are the two halves the instruction could occupy
    // allow chains slot 1 behind slot 0
    function automatic slot_t build_slot(win_half_t first, win_half_t second, pc_t pc,
                                         logic allow);
        slot_t s;
        logic  rv;
        rv = (first.data[1:0] == 2'b11);
        s.valid   = allow && first.avail && (!rv || second.avail);
        s.pc      = pc;
        s.next_pc = pc + (rv ? pc_t'(4) : pc_t'(2));
        s.is_rv   = rv;
        if (rv) begin
            s.instr = {second.data, first.data};
        end else begin
            s.instr = {{HALF_WIDTH{1'b0}}, first.data};
        end
        // fault of the first half wins, the second half only counts for 32-bit
        if (first.excp_valid) begin
            s.excp_valid = 1'b1;
            s.ecause     = first.ecause;
        end else if (rv && second.excp_valid) begin
            s.excp_valid = 1'b1;
            s.ecause     = second.ecause;
        end else begin
            s.excp_valid = 1'b0;
            s.ecause     = '0;
        end
        return s;
    endfunction

    // ----------------------------------------------------------------------
    // window gather
    // ----------------------------------------------------------------------

    // halfword index of pc inside the pop line
    assign start_half = pc_i[OFFSET_WIDTH-1:1];

    always_comb begin
        for (int k = 0; k < WIN_HALVES; k++) begin
            // msb of the position is the carry into the next line
            half_pos[k]  = {1'b0, start_half} + OFFSET_WIDTH'(k);
            half_line[k] = pop_line_i + LINE_IDX_WIDTH'(half_pos[k][OFFSET_WIDTH-1]);
            win[k].avail      = line_valid_i[half_line[k]];
            win[k].data       = lines_i[half_line[k]][half_pos[k][OFFSET_WIDTH-2:0]];
            win[k].excp_valid = infos_i[half_line[k]].excp_valid;
            win[k].ecause     = infos_i[half_line[k]].ecause;
        end
    end

    // ----------------------------------------------------------------------
    // slots
    // ----------------------------------------------------------------------

    assign slot0_o = build_slot(win[0], win[1], pc_i, 1'b1);

    // slot 1 starts right after slot 0, one or two halves in
    assign slot1_o = slot0_o.is_rv ?
        build_slot(win[2], win[3], slot0_o.next_pc, slot0_o.valid) :
        build_slot(win[1], win[2], slot0_o.next_pc, slot0_o.valid);

    assign len0 = slot0_o.is_rv ? 3'd2 : 3'd1;
    assign len1 = slot1_o.is_rv ? 3'd2 : 3'd1;

    // halves consumed if decode takes everything on offer, 0 to 4
    always_comb begin
        if (!slot0_o.valid) begin
            pop_halves_o = 3'd0;
        end else if (!slot1_o.valid) begin
            pop_halves_o = len0;
        end else begin
            pop_halves_o = len0 + len1;
        end
    end

endmodule

`default_nettype wire

/* logic/ibuf_top.sv */
// instruction buffer top: line stores, pointers, sync FSM and extractor
`default_nettype none

module ibuf_top #(
    parameter ibuf_pkg::pc_t RESET_PC = 32'h0000_1000
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               flush_i,
    input  wire ibuf_pkg::pc_t      flush_pc_i,
    input  wire logic               line_valid_i,
    output logic                    line_ready_o,
    input  wire ibuf_pkg::line_in_t line_i,
    input  wire logic               take_i,
    output ibuf_pkg::slot_t         slot0_o,
    output ibuf_pkg::slot_t         slot1_o
);

    import ibuf_pkg::*;

    // ----------------------------------------------------------------------
    // internal nets
    // ----------------------------------------------------------------------

    pc_t                       pc;
    logic [LINE_IDX_WIDTH-1:0] pop_line;
    logic [LINE_IDX_WIDTH-1:0] push_line;
    logic [NUM_LINES-1:0]      line_valid;
    logic                      has_free;
    logic                      store_en;
    logic [2:0]                pop_halves;
    line_data_t                line_data [NUM_LINES];
    line_info_t                line_info [NUM_LINES];

    // ----------------------------------------------------------------------
    // line storage, payload and tag kept apart
    // ----------------------------------------------------------------------

    line_regs #(
        .entry_t (line_data_t)
    ) u_data_regs (
        .clk       (clk),
        .reset     (reset),
        .wr_en_i   (store_en),
        .wr_idx_i  (push_line),
        .wr_data_i (line_i.data),
        .entries_o (line_data)
    );

    line_regs #(
        .entry_t (line_info_t)
    ) u_info_regs (
        .clk       (clk),
        .reset     (reset),
        .wr_en_i   (store_en),
        .wr_idx_i  (push_line),
        .wr_data_i (line_i.info),
        .entries_o (line_info)
    );

    // ----------------------------------------------------------------------
    // control
    // ----------------------------------------------------------------------

    ibuf_pointers #(
        .RESET_PC (RESET_PC)
    ) u_pointers (
        .clk          (clk),
        .reset        (reset),
        .flush_i      (flush_i),
        .flush_pc_i   (flush_pc_i),
        .push_i       (store_en),
        .take_i       (take_i),
        .pop_halves_i (pop_halves),
        .pc_o         (pc),
        .pop_line_o   (pop_line),
        .push_line_o  (push_line),
        .line_valid_o (line_valid),
        .has_free_o   (has_free)
    );

    fetch_sync_fsm u_sync_fsm (
        .clk          (clk),
        .reset        (reset),
        .flush_i      (flush_i),
        .line_valid_i (line_valid_i),
        .line_base_i  (line_i.info.base_pc),
        .pc_i         (pc),
        .has_free_i   (has_free),
        .line_ready_o (line_ready_o),
        .store_o      (store_en)
    );

    // decode side, purely combinational from the registers above
    insn_extract u_extract (
        .lines_i      (line_data),
        .infos_i      (line_info),
        .line_valid_i (line_valid),
        .pop_line_i   (pop_line),
        .pc_i         (pc),
        .slot0_o      (slot0_o),
        .slot1_o      (slot1_o),
        .pop_halves_o (pop_halves)
    );

endmodule

`default_nettype wire

/* testbench/ibuf_properties.sv */
// instruction buffer protocol checks on the decode and cache sides, bound into the top
`default_nettype none

module ibuf_properties (
    input wire logic            clk,
    input wire logic            reset,
    input wire logic            flush_i,
    input wire logic            take_i,
    input wire logic            line_valid_i,
    input wire logic            line_ready_i,
    input wire ibuf_pkg::slot_t slot0_i,
    input wire ibuf_pkg::slot_t slot1_i
);

    logic line_accept;

    // a line moves on any edge with valid and ready both high
    assign line_accept = line_valid_i && line_ready_i;

    // ----------------------------------------------------------------------
    // decode side
    // ----------------------------------------------------------------------

    // slot 1 only ever follows slot 0
    a_slot_order: assert property (@(posedge clk) disable iff (reset)
        slot1_i.valid |-> slot0_i.valid)
        else $error("slot1 offered without slot0");

    // nothing taken, nothing arriving, no redirect: slots hold
    a_slots_stable: assert property (@(posedge clk) disable iff (reset)
        (!take_i && !flush_i && !line_accept) |=> ($stable(slot0_i) && $stable(slot1_i)))
        else $error("slots changed with no take, no line and no flush");

    // ----------------------------------------------------------------------
    // cache side
    // ----------------------------------------------------------------------

    // after a redirect the buffer drains stale lines
    a_ready_after_flush: assert property (@(posedge clk) disable iff (reset)
        flush_i |=> line_ready_i)
        else $error("line_ready_o low in the cycle after a flush");

endmodule

bind ibuf_top ibuf_properties u_props (
    .clk          (clk),
    .reset        (reset),
    .flush_i      (flush_i),
    .take_i       (take_i),
    .line_valid_i (line_valid_i),
    .line_ready_i (line_ready_o),
    .slot0_i      (slot0_o),
    .slot1_i      (slot1_o)
);

`default_nettype wire

/* testbench/ibuf_tb.sv */
// instruction buffer testbench with LCG stimulus, a memory image model and slot checks
`default_nettype none

module ibuf_tb;

    import ibuf_pkg::*;

    localparam pc_t RESET_PC     = 32'h0000_1000;
    localparam int  DRIVE_DLY    = 10;
    localparam int  IMAGE_HALVES = 2048;
    localparam int  IMAGE_LINES  = 256;
    localparam int  IDLE_LIMIT   = 200;
    localparam int  RUN_CYCLES   = 6000;

    logic     clk = 1'b0;
    logic     reset;
    logic     flush_i;
    pc_t      flush_pc_i;
    logic     line_valid_i;
    logic     line_ready_o;
    line_in_t line_i;
    logic     take_i;
    slot_t    slot0_o;
    slot_t    slot1_o;

    // 4 KiB image that wraps on address bits 11:1
    half_t       mem_image [IMAGE_HALVES];
    logic        line_excp [IMAGE_LINES];
    ecause_t     line_cause [IMAGE_LINES];
    logic [31:0] lcg_state;

    // model and feeder state
    pc_t  model_pc;
    pc_t  next_base;
    int   stale_left;
    logic pending;
    int   idle;
    int   n_taken;
    int   n_flush;
    int   n_excp;
    int   n_straddle;

    ibuf_top #(
        .RESET_PC (RESET_PC)
    ) i_ibuf_top (
        .clk          (clk),
        .reset        (reset),
        .flush_i      (flush_i),
        .flush_pc_i   (flush_pc_i),
        .line_valid_i (line_valid_i),
        .line_ready_o (line_ready_o),
        .line_i       (line_i),
        .take_i       (take_i),
        .slot0_o      (slot0_o),
        .slot1_o      (slot1_o)
    );

    always #50 clk = ~clk;

    // ----------------------------------------------------------------------
    // random numbers and image access
    // ----------------------------------------------------------------------

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic half_t image_half(pc_t addr);
        return mem_image[addr[11:1]];
    endfunction

    // a cache line as the fetch side would return it
    function automatic line_in_t line_offer(pc_t base);
        line_in_t l;
        l.info.base_pc    = base;
        l.info.excp_valid = line_excp[base[11:4]];
        l.info.ecause     = line_cause[base[11:4]];
        for (int k = 0; k < HALVES_PER_LINE; k++) begin
            l.data[k] = image_half(base + pc_t'(2 * k));
        end
        return l;
    endfunction

    // instruction at pc where low bits 11 mean 32-bit and the first parcel's fault wins
    function automatic slot_t expected_slot(pc_t pc);
        slot_t s;
        half_t lo;
        half_t hi;
        pc_t   pc_hi;
        pc_hi        = pc + 32'd2;
        lo           = image_half(pc);
        hi           = image_half(pc_hi);
        s.valid      = 1'b1;
        s.pc         = pc;
        s.is_rv      = (lo[1:0] == 2'b11);
        s.next_pc    = s.is_rv ? pc + 32'd4 : pc_hi;
        s.instr      = s.is_rv ? {hi, lo} : {16'h0000, lo};
        s.excp_valid = 1'b0;
        s.ecause     = '0;
        if (line_excp[pc[11:4]]) begin
            s.excp_valid = 1'b1;
            s.ecause     = line_cause[pc[11:4]];
        end else if (s.is_rv && line_excp[pc_hi[11:4]]) begin
            s.excp_valid = 1'b1;
            s.ecause     = line_cause[pc_hi[11:4]];
        end
        return s;
    endfunction

    // all parcels of the instruction at pc lie below the next line still to arrive
    function automatic bit fully_buffered(pc_t pc);
        half_t lo;
        pc_t   pc_end;
        lo     = image_half(pc);
        pc_end = (lo[1:0] == 2'b11) ? pc + 32'd4 : pc + 32'd2;
        return (pc_end <= next_base);
    endfunction

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("error at %0t: %s", $time, why);
        stop_with_failure();
    endtask

    task automatic check_slot(input string name, input slot_t actual, input slot_t expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_ready(input bit actual, input bit expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: line_ready_o is %b, expected %b", $time, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_valid(input string name, input bit actual, input bit expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s.valid is %b, expected %b", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    // one slot taken by decode and compared against the model stream
    task automatic consume_slot(input string name, input slot_t actual);
        slot_t exp;
        exp = expected_slot(model_pc);
        check_slot(name, actual, exp);
        model_pc = exp.next_pc;
        idle     = 0;
        n_taken++;
        if (exp.excp_valid) begin
            n_excp++;
        end
        if (exp.is_rv && (exp.pc[3:1] == 3'd7)) begin
            n_straddle++;
        end
    endtask

    // ----------------------------------------------------------------------
    // one clock cycle that drives after the edge and observes at the falling edge
    // ----------------------------------------------------------------------

    task automatic step(input bit take_en, input bit flush_en);
        logic [31:0] r;
        slot_t       head;
        bit          offer0;
        bit          offer1;
        @(posedge clk);
        #DRIVE_DLY;
        r          = next_rand();
        flush_i    = flush_en && (r[31:26] == 6'd0);
        flush_pc_i = RESET_PC + pc_t'({r[15:5], 1'b0});
        take_i     = take_en && r[20];
        // cache holds a pending line and otherwise leaves an occasional gap
        line_valid_i = !flush_i && (pending || (r[23:21] != 3'd0));
        if (stale_left > 0) begin
            line_i = line_offer(next_base ^ 32'h0000_0100);
        end else begin
            line_i = line_offer(next_base);
        end
        @(negedge clk);
        // slots offer exactly what arrived since the last redirect
        head   = expected_slot(model_pc);
        offer0 = fully_buffered(model_pc);
        offer1 = offer0 && fully_buffered(head.next_pc);
        check_valid("slot0_o", slot0_o.valid, offer0);
        check_valid("slot1_o", slot1_o.valid, offer1);
        // everything below is what the coming rising edge does
        if (flush_i) begin
            model_pc   = flush_pc_i;
            next_base  = {flush_pc_i[31:4], 4'h0};
            stale_left = r[24] ? 2 : 1;
            pending    = 1'b0;
            idle       = 0;
            n_flush++;
        end else begin
            if (take_i && slot0_o.valid) begin
                consume_slot("slot0_o", slot0_o);
                if (slot1_o.valid) begin
                    consume_slot("slot1_o", slot1_o);
                end
            end
            if (line_valid_i && line_ready_o) begin
                pending = 1'b0;
                if (stale_left > 0) begin
                    stale_left--;
                end else begin
                    next_base = next_base + 32'd16;
                end
            end else begin
                pending = line_valid_i;
            end
        end
        if (take_en) begin
            idle++;
            if (idle > IDLE_LIMIT) begin
                abort_run("no instruction was taken for too many cycles");
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------

    initial begin
        logic [31:0] r;
        slot_t       snap0;
        slot_t       snap1;
        int          w;
        reset        = 1'b1;
        flush_i      = 1'b0;
        flush_pc_i   = '0;
        line_valid_i = 1'b0;
        line_i       = '0;
        take_i       = 1'b0;
        lcg_state    = 32'h5296;
        model_pc     = RESET_PC;
        next_base    = RESET_PC;
        stale_left   = 0;
        pending      = 1'b0;
        idle         = 0;
        n_taken      = 0;
        n_flush      = 0;
        n_excp       = 0;
        n_straddle   = 0;
        // random parcels with about one line in eight carrying a fetch fault
        for (int i = 0; i < IMAGE_HALVES; i++) begin
            r = next_rand();
            mem_image[i] = r[31:16];
        end
        for (int i = 0; i < IMAGE_LINES; i++) begin
            r = next_rand();
            line_excp[i]  = (r[31:29] == 3'd0);
            line_cause[i] = line_excp[i] ? r[21:16] : 6'd0;
        end

        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
        @(negedge clk);
        check_valid("slot0_o", slot0_o.valid, 1'b0);
        check_valid("slot1_o", slot1_o.valid, 1'b0);
        check_ready(line_ready_o, 1'b1);

        // first matching line brings up the instruction at the reset pc
        for (w = 0; w < 40 && !slot0_o.valid; w++) begin
            step(1'b0, 1'b0);
        end
        if (!slot0_o.valid) begin
            abort_run("slot0_o never became valid after the first line");
        end
        check_slot("slot0_o", slot0_o, expected_slot(RESET_PC));

        // no takes until both lines fill and then the slots freeze
        for (w = 0; w < 40 && line_ready_o; w++) begin
            step(1'b0, 1'b0);
        end
        if (line_ready_o) begin
            abort_run("line_ready_o stayed high with take_i held low");
        end
        snap0 = slot0_o;
        snap1 = slot1_o;
        repeat (8) begin
            step(1'b0, 1'b0);
            check_slot("slot0_o", slot0_o, snap0);
            check_slot("slot1_o", slot1_o, snap1);
            check_ready(line_ready_o, 1'b0);
        end

        // long random run with takes, gaps and flushes
        for (int c = 0; c < RUN_CYCLES; c++) begin
            step(1'b1, 1'b1);
        end

        if (n_taken < 1000 || n_flush == 0 || n_excp == 0 || n_straddle == 0) begin
            $display("error: random run too thin, taken %0d flushes %0d faults %0d straddles %0d",
                     n_taken, n_flush, n_excp, n_straddle);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end else begin
            $display("taken %0d flushes %0d faults %0d straddles %0d",
                     n_taken, n_flush, n_excp, n_straddle);
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sim.f */
logic/ibuf_pkg.sv
logic/line_regs.sv
logic/ibuf_pointers.sv
logic/fetch_sync_fsm.sv
logic/insn_extract.sv
logic/ibuf_top.sv
testbench/ibuf_properties.sv
testbench/ibuf_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the instruction buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ibuf_tb -f sim.f -o ibuf_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/ibuf_sim)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^TEST RESULT: PASS$'; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
